// ==== Makefile ====
# Verilator flow for the board debug shell

VERILATOR  := verilator
TOP        := tb_top
FILELIST   := vlog.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
BIN        := obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Rebuilds every time, then fails unless the pass message shows up
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(BIN) | tee /dev/stderr | grep "Verification passed" > /dev/null

clean:
	rm -rf obj_dir

// ==== design/board_top.sv ====
// ==========================================================
// Board debug top
// Keys, instruction queue, mini core and run controller, with
// the last retirement latched onto LEDs and four hex digits
// ==========================================================

`timescale 1ns/100ps

module board_top
    import dbg_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
)(
    input  logic              CLOCK_50,
    input  logic              n_rst,
    input  logic [1:0]        i_key_n,      // 1 is run/stop, 0 is step
    input  logic              i_insn_valid,
    input  logic [INSN_W-1:0] i_insn,
    output logic              o_insn_credit,
    output logic [17:0]       o_ledr,
    output logic [7:0]        o_ledg,
    output logic [6:0]        o_hex0,
    output logic [6:0]        o_hex1,
    output logic [6:0]        o_hex2,
    output logic [6:0]        o_hex3
);

    logic [1:0]           key_hit;
    logic [INSN_W-1:0]    insn_head;
    logic                 q_empty;
    logic                 core_pop;
    logic                 core_en;
    logic                 retire;
    logic [REG_IDX_W-1:0] retire_rd;
    logic [DATA_W-1:0]    retire_data;
    logic [DATA_W-1:0]    tp;
    run_state_t           state;
    run_state_t           state_q;
    logic                 done_entry;
    logic                 disp_strobe_q;
    logic [7:0]           disp_rd_q;
    logic [DATA_W-1:0]    disp_data_q;
    logic [6:0]           hex [4];

    assign done_entry = (state == ST_DONE) && (state_q != ST_DONE);

    // ==========================================================
    // Retirement display latch
    // ==========================================================
    always_ff @(posedge CLOCK_50) begin
        if (!n_rst) begin
            state_q       <= ST_STEP;
            disp_strobe_q <= 1'b0;
            disp_rd_q     <= '0;
            disp_data_q   <= '0;
        end else begin
            state_q       <= state;
            disp_strobe_q <= retire | done_entry;
            if (retire) disp_rd_q <= 8'(retire_rd);
            if (done_entry) disp_data_q <= tp;          // End code wins
            else if (retire) disp_data_q <= retire_data;
        end
    end

    assign o_ledr = {disp_strobe_q, 15'b0, state};
    assign o_ledg = disp_rd_q;
    assign o_hex0 = hex[0];
    assign o_hex1 = hex[1];
    assign o_hex2 = hex[2];
    assign o_hex3 = hex[3];

    for (genvar g = 0; g < 2; g++) begin : g_keys
        key_pulse u_key (
            .CLOCK_50 (CLOCK_50),
            .n_rst    (n_rst),
            .i_key_n  (i_key_n[g]),
            .o_pulse  (key_hit[g])
        );
    end

    for (genvar g = 0; g < 4; g++) begin : g_digits
        seg7_decoder u_seg (
            .i_nibble (disp_data_q[g*4 +: 4]),
            .o_seg    (hex[g])
        );
    end

    insn_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .CLOCK_50      (CLOCK_50),
        .n_rst         (n_rst),
        .i_insn_valid  (i_insn_valid),
        .i_insn        (i_insn),
        .i_pop         (core_pop),
        .o_insn_head   (insn_head),
        .o_empty       (q_empty),
        .o_insn_credit (o_insn_credit)
    );

    mini_core u_core (
        .CLOCK_50      (CLOCK_50),
        .n_rst         (n_rst),
        .i_en          (core_en),
        .i_empty       (q_empty),
        .i_insn        (insn_head),
        .o_pop         (core_pop),
        .o_retire      (retire),
        .o_retire_rd   (retire_rd),
        .o_retire_data (retire_data),
        .o_tp          (tp)
    );

    run_ctrl u_ctrl (
        .CLOCK_50   (CLOCK_50),
        .n_rst      (n_rst),
        .i_run_key  (key_hit[1]),
        .i_step_key (key_hit[0]),
        .i_retire   (retire),
        .i_tp       (tp),
        .o_state    (state),
        .o_core_en  (core_en)
    );

endmodule

// ==== design/dbg_pkg.sv ====
// ==========================================================
// Debug shell package
// Widths, test-point codes, controller states and the opcode
// set of the small in-order core
// ==========================================================

package dbg_pkg;

    localparam int DATA_W    = 16;                  // Register and data width
    localparam int INSN_W    = 16;
    localparam int REG_NUM   = 8;
    localparam int REG_IDX_W = $clog2(REG_NUM);

    localparam logic [DATA_W-1:0] TP_PASS = 16'h4a33;
    localparam logic [DATA_W-1:0] TP_FAIL = 16'hfae1;

    // Debug controller states, also shown on LEDR[1:0]
    typedef enum logic [1:0] {
        ST_RUN  = 2'b00,
        ST_STEP = 2'b01,
        ST_HALT = 2'b10,
        ST_DONE = 2'b11
    } run_state_t;

    // Instruction fields are op[15:12] rd[10:8] rs[6:4] imm[7:0]
    typedef enum logic [3:0] {
        OP_LDI  = 4'h1,
        OP_ADDI = 4'h2,
        OP_ADD  = 4'h3,
        OP_XOR  = 4'h4,
        OP_SHL8 = 4'h5,
        OP_TP   = 4'hf
    } opcode_t;

endpackage

// ==== design/insn_queue.sv ====
// ==========================================================
// Instruction queue
// Circular FIFO fed by an off-chip sender under credit flow
// control, one credit goes back for every pop
// ==========================================================

`timescale 1ns/100ps

module insn_queue
    import dbg_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
)(
    input  logic              CLOCK_50,
    input  logic              n_rst,
    input  logic              i_insn_valid,
    input  logic [INSN_W-1:0] i_insn,
    input  logic              i_pop,
    output logic [INSN_W-1:0] o_insn_head,
    output logic              o_empty,
    output logic              o_insn_credit
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = (PTR_W+1)'(QUEUE_DEPTH);

    logic [INSN_W-1:0] insn_mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;

    assign o_insn_head = insn_mem[rd_ptr];
    assign o_empty     = (count == '0);

    always_ff @(posedge CLOCK_50) begin
        if (i_insn_valid) begin
            insn_mem[wr_ptr] <= i_insn;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (!n_rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            o_insn_credit <= 1'b0;
        end else begin
            o_insn_credit <= i_pop;             // Credit back in the cycle after the pop
            if (i_insn_valid) wr_ptr <= wr_ptr + 1'b1;
            if (i_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({i_insn_valid, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Sender holds no credit while every slot is occupied
    a_no_overflow: assert property (@(posedge CLOCK_50) disable iff (!n_rst)
        i_insn_valid |-> (count != FULL_CNT))
        else $error("insn_queue: write without credit");

    a_no_underflow: assert property (@(posedge CLOCK_50) disable iff (!n_rst)
        i_pop |-> !o_empty)
        else $error("insn_queue: pop while empty");

endmodule

// ==== design/key_pulse.sv ====
// ==========================================================
// Key press pulse
// Synchronizes one active-low push key and emits a single
// cycle pulse on every new press
// ==========================================================

`timescale 1ns/100ps

module key_pulse (
    input  logic CLOCK_50,
    input  logic n_rst,
    input  logic i_key_n,
    output logic o_pulse
);

    logic [1:0] sync_q;     // Two-stage synchronizer
    logic [1:0] hist_q;     // Delayed copies of the synchronized level

    always_ff @(posedge CLOCK_50) begin
        if (!n_rst) begin
            sync_q  <= 2'b11;   // Released
            hist_q  <= 2'b11;
            o_pulse <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], i_key_n};
            hist_q  <= {hist_q[0], sync_q[1]};
            o_pulse <= hist_q[1] & ~hist_q[0];  // High to low means pressed
        end
    end

endmodule

// ==== design/mini_core.sv ====
// ==========================================================
// Mini core
// 16-bit in-order core that executes the queue head in every
// enabled cycle and reports each retirement one cycle later
// ==========================================================

`timescale 1ns/100ps

module mini_core
    import dbg_pkg::*;
(
    input  logic                 CLOCK_50,
    input  logic                 n_rst,
    input  logic                 i_en,
    input  logic                 i_empty,
    input  logic [INSN_W-1:0]    i_insn,
    output logic                 o_pop,
    output logic                 o_retire,
    output logic [REG_IDX_W-1:0] o_retire_rd,
    output logic [DATA_W-1:0]    o_retire_data,
    output logic [DATA_W-1:0]    o_tp
);

    opcode_t              opcode;
    logic [REG_IDX_W-1:0] rd;
    logic [REG_IDX_W-1:0] rs;
    logic [7:0]           imm;
    logic [DATA_W-1:0]    rd_val;
    logic [DATA_W-1:0]    rs_val;
    logic [DATA_W-1:0]    result;
    logic                 wr_en;
    logic [DATA_W-1:0]    regs [REG_NUM];

    assign opcode = opcode_t'(i_insn[15:12]);
    assign rd     = i_insn[10:8];
    assign rs     = i_insn[6:4];
    assign imm    = i_insn[7:0];
    assign rd_val = regs[rd];
    assign rs_val = regs[rs];
    assign o_pop  = i_en & ~i_empty;

    // ==========================================================
    // Execute
    // ==========================================================
    always_comb begin
        result = '0;
        wr_en  = 1'b0;
        case (opcode)
            OP_LDI: begin
                result = DATA_W'(imm);
                wr_en  = 1'b1;
            end
            OP_ADDI: begin
                result = rd_val + DATA_W'(imm);
                wr_en  = 1'b1;
            end
            OP_ADD: begin
                result = rd_val + rs_val;
                wr_en  = 1'b1;
            end
            OP_XOR: begin
                result = rd_val ^ rs_val;
                wr_en  = 1'b1;
            end
            OP_SHL8: begin
                result = {rd_val[DATA_W-9:0], imm};
                wr_en  = 1'b1;
            end
            OP_TP:   result = rd_val;               // Reported, not written back
            default: result = '0;                   // No-op still retires
        endcase
    end

    // ==========================================================
    // Register file and retire report
    // ==========================================================
    always_ff @(posedge CLOCK_50) begin
        if (!n_rst) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
            o_retire <= 1'b0;
            o_tp     <= '0;
        end else begin
            o_retire <= o_pop;
            if (o_pop && wr_en) regs[rd] <= result;
            if (o_pop && (opcode == OP_TP)) o_tp <= rd_val;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (o_pop) begin
            o_retire_rd   <= rd;
            o_retire_data <= result;
        end
    end

    // Queue head must hold a written instruction when it is taken
    a_insn_known: assert property (@(posedge CLOCK_50) disable iff (!n_rst)
        o_pop |-> !$isunknown(i_insn))
        else $error("mini_core: unknown instruction popped");

endmodule

// ==== design/run_ctrl.sv ====
// ==========================================================
// Run controller
// Run, step, halt and done debug FSM driven by the two keys,
// the retire strobe and the test point, gives the core enable
// ==========================================================

`timescale 1ns/100ps

module run_ctrl
    import dbg_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              n_rst,
    input  logic              i_run_key,
    input  logic              i_step_key,
    input  logic              i_retire,
    input  logic [DATA_W-1:0] i_tp,
    output run_state_t        o_state,
    output logic              o_core_en
);

    run_state_t next_state;
    logic       tp_hit;

    assign tp_hit = (i_tp == TP_PASS) || (i_tp == TP_FAIL);

    // Retire pulse trails the pop by one cycle, so the stopping
    // retirement also masks the cycle before the state moves on
    assign o_core_en = ((o_state == ST_RUN) & ~(i_retire & tp_hit)) |
                       ((o_state == ST_STEP) & ~i_retire);

    always_comb begin
        next_state = o_state;
        case (o_state)
            ST_RUN: begin
                if (tp_hit) next_state = ST_DONE;
                else if (i_run_key) next_state = ST_STEP;  // One-shot stop
            end
            ST_STEP: begin
                if (i_retire) next_state = ST_HALT;
            end
            default: begin                                // ST_HALT and ST_DONE
                if (i_run_key) next_state = ST_RUN;
                else if (i_step_key) next_state = ST_STEP;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (!n_rst) begin
            o_state <= ST_STEP;     // Bring-up starts single stepping
        end else begin
            o_state <= next_state;
        end
    end

    a_state_known: assert property (@(posedge CLOCK_50) disable iff (!n_rst)
        !$isunknown(o_state))
        else $error("run_ctrl: state unknown");

endmodule

// ==== design/seg7_decoder.sv ====
// ==========================================================
// Seven-segment decoder
// Hex nibble to active-low segment pattern, bit 0 is seg a
// ==========================================================

`timescale 1ns/100ps

module seg7_decoder (
    input  logic [3:0] i_nibble,
    output logic [6:0] o_seg
);

    always_comb begin
        case (i_nibble)
            4'h0: o_seg = 7'b1000000;
            4'h1: o_seg = 7'b1111001;
            4'h2: o_seg = 7'b0100100;
            4'h3: o_seg = 7'b0110000;
            4'h4: o_seg = 7'b0011001;
            4'h5: o_seg = 7'b0010010;
            4'h6: o_seg = 7'b0000010;
            4'h7: o_seg = 7'b1111000;
            4'h8: o_seg = 7'b0000000;
            4'h9: o_seg = 7'b0010000;
            4'ha: o_seg = 7'b0001000;
            4'hb: o_seg = 7'b0000011;   // Lower case b
            4'hc: o_seg = 7'b1000110;
            4'hd: o_seg = 7'b0100001;   // Lower case d
            4'he: o_seg = 7'b0000110;
            default: o_seg = 7'b0001110;
        endcase
    end

endmodule

// ==== tests/core_stim.txt ====
# Columns: command letter, then one hex value
# I insn = send instruction, K n = press key n (0 step, 1 run), W n = idle cycles, E code = end code
E 4a33
I 1105
I 1237
I 2110
I 3120
I 4210
K 0
K 0
I 5312
I 5334
K 1
I 0000
I 2aff
I 144a
I 5433
I f400
W 8
I 3520
K 0
I f600
K 0
I 4540
I 9000
K 1
I f400
W 12

// ==== tests/tb_checker.sv ====
// ==========================================================
// Display checker
// Keeps a reference model of the small core fed from the
// instruction port and compares LEDs and digits at every strobe
// ==========================================================

`timescale 1ns/100ps

module tb_checker
    import dbg_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
)(
    input  logic              CLOCK_50,
    input  logic              n_rst,
    input  logic              i_insn_valid,
    input  logic [INSN_W-1:0] i_insn,
    input  logic              i_insn_credit,
    input  logic [17:0]       i_ledr,
    input  logic [7:0]        i_ledg,
    input  logic [6:0]        i_hex0,
    input  logic [6:0]        i_hex1,
    input  logic [6:0]        i_hex2,
    input  logic [6:0]        i_hex3,
    input  logic [DATA_W-1:0] i_end_code,
    input  logic              i_end_req,
    output logic              o_end_ack,
    output int                o_errors,
    output int                o_retired,
    output int                o_credits
);

    logic [DATA_W-1:0] model_regs [REG_NUM];
    logic [INSN_W-1:0] pending_q [$];
    logic [1:0]        prev_state;
    logic [7:0]        last_rd_led;
    logic              fresh_reset;
    logic              done_pending;
    int                outstanding;
    int                step_base;
    int                done_loads;

    // Lit segments as gfedcba before the active-low inversion
    function automatic logic [6:0] seg_pattern(input logic [3:0] nib);
        logic [6:0] lit;
        case (nib)
            4'h0: lit = 7'h3f;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5b;
            4'h3: lit = 7'h4f;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6d;
            4'h6: lit = 7'h7d;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7f;
            4'h9: lit = 7'h6f;
            4'ha: lit = 7'h77;
            4'hb: lit = 7'h7c;
            4'hc: lit = 7'h39;
            4'hd: lit = 7'h5e;
            4'he: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    function automatic logic [27:0] digits_of(input logic [DATA_W-1:0] value);
        return {seg_pattern(value[15:12]), seg_pattern(value[11:8]),
                seg_pattern(value[7:4]), seg_pattern(value[3:0])};
    endfunction

    task automatic report_fail(input string msg);
        o_errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    task automatic report_problem(input string msg);
        o_errors++;
        $display("%s", msg);
    endtask

    task automatic execute_model(input  logic [INSN_W-1:0] insn,
                                 output logic [2:0]        rd,
                                 output logic [DATA_W-1:0] res);
        logic [2:0] rs;
        logic [7:0] imm;
        logic       wr;
        rd  = insn[10:8];
        rs  = insn[6:4];
        imm = insn[7:0];
        wr  = 1'b1;
        case (insn[15:12])
            OP_LDI:  res = {8'h00, imm};
            OP_ADDI: res = model_regs[rd] + {8'h00, imm};
            OP_ADD:  res = model_regs[rd] + model_regs[rs];
            OP_XOR:  res = model_regs[rd] ^ model_regs[rs];
            OP_SHL8: res = {model_regs[rd][7:0], imm};
            OP_TP: begin
                res = model_regs[rd];       // Test point only
                wr  = 1'b0;
            end
            default: begin
                res = '0;
                wr  = 1'b0;
            end
        endcase
        if (wr) model_regs[rd] = res;
    endtask

    task automatic check_retirement();
        logic [INSN_W-1:0] insn;
        logic [2:0]        rd;
        logic [DATA_W-1:0] res;
        logic [27:0]       got;
        got = {i_hex3, i_hex2, i_hex1, i_hex0};
        if (pending_q.size() == 0) begin
            report_problem("Display strobe with no instruction left to retire");
        end else begin
            insn = pending_q.pop_front();
            execute_model(insn, rd, res);
            o_retired++;
            last_rd_led = {5'b0, rd};
            if (i_ledg != last_rd_led || got != digits_of(res)) begin
                report_fail($sformatf("insn %h expected rd %0d data %h, got ledg %h hex %h",
                                      insn, rd, res, i_ledg, got));
            end
        end
    endtask

    task automatic check_done_load();
        logic [27:0] got;
        got = {i_hex3, i_hex2, i_hex1, i_hex0};
        done_loads++;
        if (i_ledr[1:0] != ST_DONE || i_ledg != last_rd_led
                || got != digits_of(i_end_code)) begin
            report_fail($sformatf("done load expected code %h, got state %0d ledg %h hex %h",
                                  i_end_code, i_ledr[1:0], i_ledg, got));
        end
    endtask

    task automatic follow_state();
        logic [1:0] cur;
        cur = i_ledr[1:0];
        if (cur == ST_STEP && prev_state != ST_STEP) step_base = o_retired;
        if (cur == ST_HALT && prev_state == ST_STEP && o_retired - step_base != 1) begin
            report_fail($sformatf("step retired %0d instructions", o_retired - step_base));
        end
        if (cur == ST_DONE && prev_state != ST_DONE) done_pending = 1'b1;  // Load comes next
        prev_state = cur;
    endtask

    task automatic final_checks();
        if (pending_q.size() != 0) begin
            report_problem($sformatf("%0d sent instructions never retired", pending_q.size()));
        end
        if (o_credits != o_retired) begin
            report_problem($sformatf("%0d credit pulses returned for %0d retirements",
                                     o_credits, o_retired));
        end
        if (done_loads == 0) report_problem("The run never reached the done state");
    endtask

    // ==========================================================
    // Sampling at the falling edge
    // ==========================================================
    always @(negedge CLOCK_50) begin
        if (!n_rst) begin
            for (int i = 0; i < REG_NUM; i++) begin
                model_regs[i] = '0;
            end
            pending_q.delete();
            prev_state   = ST_STEP;
            last_rd_led  = '0;
            fresh_reset  = 1'b1;
            done_pending = 1'b0;
            outstanding  = 0;
            step_base    = 0;
            done_loads   = 0;
            o_end_ack    = 1'b0;
            o_errors     = 0;
            o_retired    = 0;
            o_credits    = 0;
        end else begin
            if (fresh_reset && (i_ledr != 18'(ST_STEP) || i_ledg != '0
                    || {i_hex3, i_hex2, i_hex1, i_hex0} != digits_of('0))) begin
                report_fail("display not cleared after reset");
            end
            fresh_reset = 1'b0;
            if (i_insn_valid) begin
                pending_q.push_back(i_insn);
                outstanding++;
            end
            if (i_insn_credit) begin
                o_credits++;
                outstanding--;
            end
            if (outstanding < 0) report_problem("Credit returned with nothing outstanding");
            if (i_ledr[16:2] != '0) report_fail($sformatf("unused LEDR bits %h", i_ledr));
            if (i_ledr[17]) begin
                if (done_pending) check_done_load();
                else check_retirement();
                done_pending = 1'b0;
            end
            // Sent but not yet shown as retired
            if (pending_q.size() > QUEUE_DEPTH) begin
                report_problem("More instructions in flight than the queue depth");
            end
            follow_state();
            if (i_end_req && !o_end_ack) begin
                final_checks();
                o_end_ack = 1'b1;
            end
        end
    end

endmodule

// ==== tests/tb_top.sv ====
// ==========================================================
// Debug shell testbench
// Replays the stimulus file into the instruction port and the
// two keys, tracks sender credits and limits the run length
// ==========================================================

`timescale 1ns/100ps

module tb_top
    import dbg_pkg::*;
();

    localparam int    QUEUE_DEPTH = 4;
    localparam string STIM_FILE   = "tests/core_stim.txt";

    logic              CLOCK_50 = 1'b0;
    logic              n_rst;
    logic [1:0]        key_n;
    logic              insn_valid;
    logic [INSN_W-1:0] insn;
    logic              insn_credit;
    logic [17:0]       ledr;
    logic [7:0]        ledg;
    logic [6:0]        hex0;
    logic [6:0]        hex1;
    logic [6:0]        hex2;
    logic [6:0]        hex3;
    logic [DATA_W-1:0] end_code;
    logic              end_req;
    logic              end_ack;
    int                errors;
    int                retired;
    int                credits;
    byte               cmd_kind [$];
    logic [31:0]       cmd_val [$];
    int                sent_cnt;
    int                returned_cnt;
    int                cycle_limit = 0;
    int                cycles;
    bit                stim_bad;

    always #4 CLOCK_50 = ~CLOCK_50;

    board_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_dut (
        .CLOCK_50      (CLOCK_50),
        .n_rst         (n_rst),
        .i_key_n       (key_n),
        .i_insn_valid  (insn_valid),
        .i_insn        (insn),
        .o_insn_credit (insn_credit),
        .o_ledr        (ledr),
        .o_ledg        (ledg),
        .o_hex0        (hex0),
        .o_hex1        (hex1),
        .o_hex2        (hex2),
        .o_hex3        (hex3)
    );

    tb_checker #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_chk (
        .CLOCK_50      (CLOCK_50),
        .n_rst         (n_rst),
        .i_insn_valid  (insn_valid),
        .i_insn        (insn),
        .i_insn_credit (insn_credit),
        .i_ledr        (ledr),
        .i_ledg        (ledg),
        .i_hex0        (hex0),
        .i_hex1        (hex1),
        .i_hex2        (hex2),
        .i_hex3        (hex3),
        .i_end_code    (end_code),
        .i_end_req     (end_req),
        .o_end_ack     (end_ack),
        .o_errors      (errors),
        .o_retired     (retired),
        .o_credits     (credits)
    );

    always @(negedge CLOCK_50) begin
        if (!n_rst) returned_cnt = 0;
        else if (insn_credit) returned_cnt = returned_cnt + 1;    // One credit per pulse
    end

    task automatic next_cycle();
        @(posedge CLOCK_50);
        #1;
    endtask

    task automatic load_stim();
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [31:0] value;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %s", STIM_FILE);
            stim_bad = 1'b1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                kind = line.getc(0);
                if (kind == "I" || kind == "K" || kind == "W" || kind == "E") begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h", value);
                    if (n == 1) begin
                        cmd_kind.push_back(kind);
                        cmd_val.push_back(value);
                    end else begin
                        $display("Malformed stimulus line: %s", line);
                        stim_bad = 1'b1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Waits for a credit, then holds valid for one cycle
    task automatic send_insn(input logic [INSN_W-1:0] word);
        while (sent_cnt - returned_cnt >= QUEUE_DEPTH) begin
            next_cycle();
        end
        insn_valid = 1'b1;
        insn       = word;
        sent_cnt++;
        next_cycle();
        insn_valid = 1'b0;
    endtask

    task automatic press_key(input int num);
        key_n[num] = 1'b0;
        repeat (3) next_cycle();
        key_n[num] = 1'b1;
        repeat (3) next_cycle();
    endtask

    // ==========================================================
    // Stimulus
    // ==========================================================
    initial begin
        n_rst      = 1'b0;
        key_n      = 2'b11;     // Keys released
        insn_valid = 1'b0;
        insn       = '0;
        end_code   = '0;
        end_req    = 1'b0;
        sent_cnt   = 0;
        load_stim();
        cycle_limit = 40 * cmd_kind.size() + 200;
        repeat (2) @(posedge CLOCK_50);
        #1;
        n_rst = 1'b1;
        for (int i = 0; i < cmd_kind.size(); i++) begin
            case (cmd_kind[i])
                "I":     send_insn(cmd_val[i][INSN_W-1:0]);
                "K":     press_key(int'(cmd_val[i][0]));
                "W":     repeat (cmd_val[i]) next_cycle();
                default: end_code = cmd_val[i][DATA_W-1:0];
            endcase
        end
        while (returned_cnt != sent_cnt) begin
            next_cycle();
        end
        repeat (2) next_cycle();    // Display strobe and done load trail the last credit
        end_req = 1'b1;
        wait (end_ack);
        $display("Errors %0d, sent %0d, retired %0d, credits returned %0d",
                 errors + int'(stim_bad), sent_cnt, retired, credits);
        if (errors == 0 && !stim_bad) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge CLOCK_50);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
design/dbg_pkg.sv
design/key_pulse.sv
design/seg7_decoder.sv
design/insn_queue.sv
design/mini_core.sv
design/run_ctrl.sv
design/board_top.sv
tests/tb_checker.sv
tests/tb_top.sv
